/* verilog.f */
+incdir+source
source/aluCorePkg.sv
source/phaseSequencer.sv
source/aluGroupDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/aluCore.sv
test/aluCore_chk.sv
test/aluCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the ALU core testbench with Verilator and runs it.
# The simulator's exit status is the test result.
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --assert -j 0 \
	--top-module aluCoreTb \
	-f verilog.f \
	-o aluCoreSim

./obj_dir/aluCoreSim

/* test/aluCore_tests.txt */
# name instr wbValid wbAddr wbData flags, all fields after the name in hex
# flags packs Z N C from bit 2 down to bit 0, and wbAddr/wbData only count when wbValid is 1
ldRbByte C234 1 2 0034 0
ldRaHighByte C312 1 1 1234 0
movR3R1 C031 1 3 1234 0
ldRbFF C2FF 1 2 00FF 0
ldRaFF C3FF 1 1 FFFF 0
addCarryOut C412 1 1 00FE 1
adcCarryIn C832 1 3 1334 0
subBorrow CC23 1 2 EDCB 3
sbcBorrowIn D031 1 3 1235 0
subToZero CC33 1 3 0000 4
addU4 C537 1 3 0007 0
andU4 D52F 1 2 000B 0
orRegReg D812 1 1 00FF 0
xorU4 DD1F 1 1 00F0 0
notRegReg E041 1 4 FF0F 2
negU4 E551 1 5 FFFF 3
shlCarry E864 1 6 FE1E 3
shrCarry EC74 1 7 7F87 1
rolCarry F084 1 8 FE1F 3
rorU4 F591 1 9 8000 3
incWrap F8A5 1 a 0000 5
decU4 FDB0 1 b FFFF 3
movKeepsFlags C0C7 1 c 7F87 3
systemGroup 1234 0 0 0000 3
loadStoreGroup 4ABC 0 0 0000 3
jumpGroup 8F21 0 0 0000 3
adcAfterIdle C8C9 1 c FF88 2

/* test/aluCoreTb.sv */
// Testbench for the ALU core, driven by the vectors in the tests file.
`timescale 1ns/1ps
`default_nettype none

module aluCoreTb import aluCorePkg::*; ();

	// one instruction and what it should leave behind.
	typedef struct packed {
		logic [15:0] instr;
		logic        wbValid;
		logic [3:0]  wbAddr;
		logic [15:0] wbData;
		ccFlags_t    flags;
	} testVec_t;

	logic        CLK = 1'b0;
	logic        reset;
	logic [15:0] instr;
	logic        instrValid;
	logic        retire;
	logic        wbValid;
	logic [3:0]  wbAddr;
	logic [15:0] wbData;
	ccFlags_t    flags;

	testVec_t    vectors[$];
	string       names[$];
	int          cycleCount = 0;
	int          timeoutLimit = 50;

	aluCore aluCore_i (
		.CLK(CLK),
		.reset(reset),
		.instr(instr),
		.instrValid(instrValid),
		.retire(retire),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.flags(flags)
	);

	// 20 ns clock.
	always #10 CLK = ~CLK;

	// hang guard, limit follows the number of vectors.
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit) begin
			$display("run hung, no end after %0d cycles", cycleCount);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	// compare and stop at the first difference.
	task automatic checkValue(input string testName, input string field,
		input logic [15:0] expected, input logic [15:0] actual);
		if (expected !== actual) begin
			$display("MISMATCH %s %s expected %h actual %h",
				testName, field, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// pulls every vector line into the queues, '#' lines are notes.
	task automatic readTests();
		int          fd;
		int          fields;
		string       line;
		string       name;
		logic [15:0] fInstr;
		logic [15:0] fValid;
		logic [15:0] fAddr;
		logic [15:0] fData;
		logic [15:0] fFlags;
		testVec_t    vec;
		fd = $fopen("test/aluCore_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open test/aluCore_tests.txt");
			$display("Result: FAILED");
			$fatal(1, "missing tests file");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) != "#") begin
				fields = $sscanf(line, "%s %h %h %h %h %h",
					name, fInstr, fValid, fAddr, fData, fFlags);
				if (fields == 6) begin
					vec.instr   = fInstr;
					vec.wbValid = fValid[0];
					vec.wbAddr  = fAddr[3:0];
					vec.wbData  = fData;
					vec.flags   = fFlags[2:0];
					vectors.push_back(vec);
					names.push_back(name);
				end else if (fields > 0) begin
					$display("malformed line in tests file: %s", line);
					$display("Result: FAILED");
					$fatal(1, "bad tests file");
				end
			end
		end
		$fclose(fd);
	endtask

	// one instruction from strobe to the cycles after retire.
	task automatic runTest(input string name, input testVec_t vec);
		@(posedge CLK);
		#1;
		instr      = vec.instr;
		instrValid = 1'b1;
		@(posedge CLK);
		#1;
		instrValid = 1'b0;
		// second strobe lands in decode and must be dropped.
		@(posedge CLK);
		#1;
		instr      = ~vec.instr;
		instrValid = 1'b1;
		@(posedge CLK);
		#1;
		instrValid = 1'b0;
		// outputs are sampled on the falling edge.
		do begin
			@(negedge CLK);
		end while (!retire);
		checkValue(name, "wbValid", {15'd0, vec.wbValid}, {15'd0, wbValid});
		if (vec.wbValid) begin
			checkValue(name, "wbAddr", {12'd0, vec.wbAddr}, {12'd0, wbAddr});
			checkValue(name, "wbData", vec.wbData, wbData);
		end
		checkValue(name, "flags", {13'd0, vec.flags}, {13'd0, flags});
		// an accepted busy strobe would retire within these two cycles.
		repeat (2) begin
			@(negedge CLK);
			checkValue(name, "extra retire", 16'd0, {15'd0, retire});
			checkValue(name, "extra wbValid", 16'd0, {15'd0, wbValid});
		end
	endtask

	initial begin
		reset      = 1'b1;
		instr      = 16'd0;
		instrValid = 1'b0;
		readTests();
		if (vectors.size() == 0) begin
			$display("tests file holds no vectors");
			$display("Result: FAILED");
			$fatal(1, "empty tests file");
		end
		timeoutLimit = vectors.size() * 8 + 50;
		// reset for 8 cycles.
		repeat (8) @(posedge CLK);
		#1;
		reset = 1'b0;
		@(negedge CLK);
		checkValue("reset", "retire", 16'd0, {15'd0, retire});
		checkValue("reset", "wbValid", 16'd0, {15'd0, wbValid});
		checkValue("reset", "flags", 16'd0, {13'd0, flags});
		// flags carry over from one vector to the next.
		foreach (vectors[i]) begin
			runTest(names[i], vectors[i]);
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/aluCore_chk.sv */
// Bound assertions on the ALU core's retire and write-back timing.
`timescale 1ns/1ps
`default_nettype none

module aluCore_chk (
	input wire CLK,
	input wire reset,
	input wire instrValid,
	input wire fetch,
	input wire decode,
	input wire execute,
	input wire commit,
	input wire retire,
	input wire wbValid
);

	wire idle;

	// no phase level and no retire means the sequencer sits in idle.
	assign idle = !(fetch || decode || execute || commit || retire);

	// a register write only shows up in the retire cycle.
	wbInRetire: assert property (@(posedge CLK) disable iff (reset)
		wbValid |-> retire)
		else $error("write-back seen outside the retire cycle");

	// retire is a one-cycle pulse.
	retireOneCycle: assert property (@(posedge CLK) disable iff (reset)
		retire |=> !retire)
		else $error("retire held for more than one cycle");

	// an accepted strobe retires five cycles later.
	startToRetire: assert property (@(posedge CLK) disable iff (reset)
		(instrValid && idle) |-> ##5 retire)
		else $error("accepted instruction did not retire five cycles later");

endmodule

bind aluCore aluCore_chk aluCore_chk_i (
	.CLK(CLK),
	.reset(reset),
	.instrValid(instrValid),
	.fetch(fetch),
	.decode(decode),
	.execute(execute),
	.commit(commit),
	.retire(retire),
	.wbValid(wbValid)
);

`default_nettype wire

/* source/aluCore.sv */
// ALU core top tying sequencer, decoder, register file and ALU together.
`timescale 1ns/1ps
`default_nettype none

module aluCore import aluCorePkg::*; (
	input  wire         CLK,
	input  wire         reset,
	input  wire  [15:0] instr,
	input  wire         instrValid,
	output logic        retire,
	output logic        wbValid,
	output logic [3:0]  wbAddr,
	output logic [15:0] wbData,
	output ccFlags_t    flags
);

	aluInstr_t   instrWord;
	regCtrl_t    regCtrl;
	aluCtrl_t    aluCtrl;
	logic        fetch;
	logic        decode;
	logic        execute;
	logic        commit;
	logic [15:0] rdA;
	logic [15:0] rdB;

	phaseSequencer phaseSequencer_i (
		.CLK(CLK), .reset(reset), .instr(instr), .instrValid(instrValid),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
		.retire(retire), .instrWord(instrWord)
	);

	aluGroupDecoder aluGroupDecoder_i (
		.CLK(CLK), .reset(reset), .instrWord(instrWord),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
		.regCtrl(regCtrl), .aluCtrl(aluCtrl)
	);

	// ALU result is both the write data and the observed write-back value.
	registerFile registerFile_i (
		.CLK(CLK), .reset(reset), .regCtrl(regCtrl),
		.argA(aluCtrl.argA), .argB(aluCtrl.argB), .wrData(wbData),
		.rdA(rdA), .rdB(rdB), .wbAddr(wbAddr), .wbValid(wbValid)
	);

	aluUnit aluUnit_i (
		.CLK(CLK), .reset(reset), .aluCtrl(aluCtrl),
		.rdA(rdA), .rdB(rdB), .result(wbData), .flags(flags)
	);

endmodule

`default_nettype wire

/* source/aluUnit.sv */
// ALU with operand source muxes, sixteen operations and the Z/N/C flag register.
`timescale 1ns/1ps
`default_nettype none
`include "aluCore_consts.svh"

module aluUnit import aluCorePkg::*; (
	input  wire         CLK,
	input  wire         reset,
	input  aluCtrl_t    aluCtrl,
	input  wire  [15:0] rdA,
	input  wire  [15:0] rdB,
	output logic [15:0] result,
	output ccFlags_t    flags
);

	aluOperand_u imm;
	logic [15:0] opA;
	logic [15:0] opB;
	logic [16:0] wide;
	logic        carryIn;

	// nibble pair from the decoder, read back as one byte where needed.
	assign imm = {aluCtrl.argA, aluCtrl.argB};

	assign opA = (aluCtrl.aluASrcX == `ALUA_SRCX_ZERO) ? 16'd0 : rdA;

	always_comb begin
		case (aluCtrl.aluBSrcX)
			`ALUB_SRCX_U4:  opB = {12'd0, imm.regs.argB};
			`ALUB_SRCX_U8:  opB = {8'd0, imm.u8};
			`ALUB_SRCX_U8H: opB = {imm.u8, rdB[7:0]};
			default:        opB = rdB;
		endcase
	end

	// bit 16 is carry or borrow out, zero for logic operations.
	always_comb begin
		wide = 17'd0;
		case (aluCtrl.aluOp)
			`ALU_OPX_MOV: wide = {1'b0, opB};
			`ALU_OPX_ADD: wide = {1'b0, opA} + {1'b0, opB};
			`ALU_OPX_ADC: wide = {1'b0, opA} + {1'b0, opB} + {16'd0, carryIn};
			`ALU_OPX_SUB: wide = {1'b0, opA} - {1'b0, opB};
			`ALU_OPX_SBC: wide = {1'b0, opA} - {1'b0, opB} - {16'd0, carryIn};
			`ALU_OPX_AND: wide = {1'b0, opA & opB};
			`ALU_OPX_OR:  wide = {1'b0, opA | opB};
			`ALU_OPX_XOR: wide = {1'b0, opA ^ opB};
			`ALU_OPX_NOT: wide = {1'b0, ~opB};
			`ALU_OPX_NEG: wide = 17'd0 - {1'b0, opB};
			// shifts and rotates put the bit shifted out on top.
			`ALU_OPX_SHL: wide = {opB, 1'b0};
			`ALU_OPX_SHR: wide = {opB[0], 1'b0, opB[15:1]};
			`ALU_OPX_ROL: wide = {opB[15], opB[14:0], opB[15]};
			`ALU_OPX_ROR: wide = {opB[0], opB[0], opB[15:1]};
			`ALU_OPX_INC: wide = {1'b0, opB} + 17'd1;
			`ALU_OPX_DEC: wide = {1'b0, opB} - 17'd1;
			default:      wide = 17'd0;
		endcase
	end

	assign result = wide[15:0];

	// carry used by ADC and SBC.
	// frozen across the flag load so write-back sees the same sum.
	always_ff @(posedge CLK) begin
		if (reset) begin
			carryIn <= 1'b0;
		end else if (!aluCtrl.cclLd) begin
			carryIn <= flags.carry;
		end
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			flags <= '0;
		end else if (aluCtrl.cclLd) begin
			flags.zero     <= (wide[15:0] == 16'd0);
			flags.negative <= wide[15];
			flags.carry    <= wide[16];
		end
	end

endmodule

`default_nettype wire

/* source/registerFile.sv */
// Register file of sixteen 16-bit registers with two read ports and a port A write.
`timescale 1ns/1ps
`default_nettype none
`include "aluCore_consts.svh"

module registerFile import aluCorePkg::*; (
	input  wire         CLK,
	input  wire         reset,
	input  regCtrl_t    regCtrl,
	input  wire  [3:0]  argA,
	input  wire  [3:0]  argB,
	input  wire  [15:0] wrData,
	output logic [15:0] rdA,
	output logic [15:0] rdB,
	output logic [3:0]  wbAddr,
	output logic        wbValid
);

	logic [15:0] regs [16];
	logic [3:0]  addrA;
	logic [3:0]  addrB;

	// address selects to register numbers.
	always_comb begin
		case (regCtrl.regAAddrX)
			`REGA_ADDRX_RA: addrA = `REG_RA;
			`REGA_ADDRX_RB: addrA = `REG_RB;
			default:        addrA = argA;
		endcase
		case (regCtrl.regBAddrX)
			`REGB_ADDRX_RB: addrB = `REG_RB;
			default:        addrB = argB;
		endcase
	end

	// disabled ports read as zero.
	assign rdA = regCtrl.regAEn ? regs[addrA] : 16'd0;
	assign rdB = regCtrl.regBEn ? regs[addrB] : 16'd0;

	// port A wins if both ports ever hit the same register.
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 16'd0;
			end
		end else begin
			if (regCtrl.regBEn && regCtrl.regBWen) begin
				regs[addrB] <= wrData;
			end
			if (regCtrl.regAEn && regCtrl.regAWen) begin
				regs[addrA] <= wrData;
			end
		end
	end

	assign wbAddr  = addrA;
	assign wbValid = regCtrl.regAWen;

endmodule

`default_nettype wire

/* source/aluGroupDecoder.sv */
// ALU group decoder producing register file and ALU controls for each phase.
`timescale 1ns/1ps
`default_nettype none
`include "aluCore_consts.svh"

module aluGroupDecoder import aluCorePkg::*; (
	input  wire        CLK,
	input  wire        reset,
	input  aluInstr_t  instrWord,
	input  wire        fetch,
	input  wire        decode,
	input  wire        execute,
	input  wire        commit,
	output regCtrl_t   regCtrl,
	output aluCtrl_t   aluCtrl
);

	logic       isAlu;
	logic       rdA;
	logic       rdB;
	logic       wrA;
	logic [1:0] aAddrX;
	logic [2:0] bAddrX;
	logic [2:0] aSrcX;
	logic [2:0] bSrcX;
	logic       inPhase;
	logic       regAEn;
	logic       regBEn;
	logic       regAWen;
	logic       cclLd;

	assign isAlu   = (instrWord.group == `GROUP_ARITHMETIC_LOGIC);
	assign inPhase = decode | execute | commit;

	// mode decode that stays quiet outside group 3.
	always_comb begin
		rdA    = 1'b0;
		rdB    = 1'b0;
		wrA    = 1'b0;
		aAddrX = `REGA_ADDRX_ARGA;
		bAddrX = `REGB_ADDRX_ARGB;
		aSrcX  = `ALUA_SRCX_REG_A;
		bSrcX  = `ALUB_SRCX_REG_B;
		if (isAlu) begin
			case (instrWord.argF)
				`MODE_ALU_REG_REG: begin
					rdA = 1'b1;
					rdB = 1'b1;
					wrA = 1'b1;
				end
				`MODE_ALU_REG_U4: begin
					bSrcX = `ALUB_SRCX_U4;
					rdA   = 1'b1;
					wrA   = 1'b1;
				end
				`MODE_ALU_REGB_U8: begin
					// result lands in RB with the A side forced to zero.
					aAddrX = `REGA_ADDRX_RB;
					aSrcX  = `ALUA_SRCX_ZERO;
					bSrcX  = `ALUB_SRCX_U8;
					rdA    = 1'b1;
					wrA    = 1'b1;
				end
				default: begin
					// byte goes high over RB's low byte and the result goes into RA.
					aAddrX = `REGA_ADDRX_RA;
					bAddrX = `REGB_ADDRX_RB;
					aSrcX  = `ALUA_SRCX_ZERO;
					bSrcX  = `ALUB_SRCX_U8H;
					rdA    = 1'b1;
					rdB    = 1'b1;
					wrA    = 1'b1;
				end
			endcase
		end
	end

	// phase enables trail the phase level by one cycle.
	always_ff @(posedge CLK) begin
		if (reset || fetch || !inPhase) begin
			regAEn  <= 1'b0;
			regBEn  <= 1'b0;
			regAWen <= 1'b0;
			cclLd   <= 1'b0;
		end else if (decode || execute) begin
			regAEn  <= rdA;
			regBEn  <= rdB;
			regAWen <= 1'b0;
			// flags load in the cycle after execute and MOV leaves them alone.
			cclLd   <= execute && isAlu && (instrWord.aluOp != `ALU_OPX_MOV);
		end else begin
			// commit keeps the reads open so the result holds during the write.
			regAEn  <= rdA | wrA;
			regBEn  <= rdB;
			regAWen <= wrA;
			cclLd   <= 1'b0;
		end
	end

	// port B is never written.
	assign regCtrl = '{regAEn: regAEn, regBEn: regBEn, regAWen: regAWen,
		regBWen: 1'b0, regAAddrX: aAddrX, regBAddrX: bAddrX};

	assign aluCtrl = '{aluOp: instrWord.aluOp, aluASrcX: aSrcX, aluBSrcX: bSrcX,
		cclLd: cclLd, argA: instrWord.operand.regs.argA,
		argB: instrWord.operand.regs.argB};

endmodule

`default_nettype wire

/* source/phaseSequencer.sv */
// Phase sequencer that latches one instruction and steps it from fetch to writeback.
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer import aluCorePkg::*; (
	input  wire         CLK,
	input  wire         reset,
	input  wire  [15:0] instr,
	input  wire         instrValid,
	output logic        fetch,
	output logic        decode,
	output logic        execute,
	output logic        commit,
	output logic        retire,
	output aluInstr_t   instrWord
);

	typedef enum logic [2:0] {
		stIdle, stFetch, stDecode, stExecute, stCommit, stWriteback
	} phase_e;

	phase_e state;

	// one step per cycle, strobes outside idle are dropped.
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle:      state <= instrValid ? stFetch : stIdle;
				stFetch:     state <= stDecode;
				stDecode:    state <= stExecute;
				stExecute:   state <= stCommit;
				stCommit:    state <= stWriteback;
				default:     state <= stIdle;
			endcase
		end
	end

	// word is held from acceptance until retire.
	always_ff @(posedge CLK) begin
		if (state == stIdle && instrValid) begin
			instrWord <= instr;
		end
	end

	assign fetch   = (state == stFetch);
	assign decode  = (state == stDecode);
	assign execute = (state == stExecute);
	assign commit  = (state == stCommit);
	// writeback cycle doubles as the retire pulse.
	assign retire  = (state == stWriteback);

endmodule

`default_nettype wire

/* source/aluCorePkg.sv */
// ALU slice types for the instruction word, the operand byte, the control bundles and the flags.
`default_nettype none

package aluCorePkg;

	// low instruction byte.
	// seen either as two register nibbles or as one immediate byte.
	typedef union packed {
		struct packed {
			logic [3:0] argA;
			logic [3:0] argB;
		} regs;
		logic [7:0] u8;
	} aluOperand_u;

	// full 16-bit instruction word, group in the top two bits.
	typedef struct packed {
		logic [1:0]  group;
		logic [3:0]  aluOp;
		logic [1:0]  argF;
		aluOperand_u operand;
	} aluInstr_t;

	// register file steering from the decoder.
	typedef struct packed {
		logic       regAEn;
		logic       regBEn;
		logic       regAWen;
		logic       regBWen;
		logic [1:0] regAAddrX;
		logic [2:0] regBAddrX;
	} regCtrl_t;

	// ALU steering from the decoder.
	typedef struct packed {
		logic [3:0] aluOp;
		logic [2:0] aluASrcX;
		logic [2:0] aluBSrcX;
		logic       cclLd;
		logic [3:0] argA;
		logic [3:0] argB;
	} aluCtrl_t;

	// condition codes.
	typedef struct packed {
		logic zero;
		logic negative;
		logic carry;
	} ccFlags_t;

endpackage

`default_nettype wire

/* source/aluCore_consts.svh */
// ALU slice constants for the group, mode, operation, source and address encodings.
`ifndef ALU_CORE_CONSTS_SVH
`define ALU_CORE_CONSTS_SVH

// instruction group that carries the ALU operations.
`define GROUP_ARITHMETIC_LOGIC 2'd3

// addressing modes held in the argument type field.
`define MODE_ALU_REG_REG    2'd0
`define MODE_ALU_REG_U4     2'd1
`define MODE_ALU_REGB_U8    2'd2
`define MODE_ALU_REGA_U8RB  2'd3

// ALU operations, one per code.
`define ALU_OPX_MOV 4'd0
`define ALU_OPX_ADD 4'd1
`define ALU_OPX_ADC 4'd2
`define ALU_OPX_SUB 4'd3
`define ALU_OPX_SBC 4'd4
`define ALU_OPX_AND 4'd5
`define ALU_OPX_OR  4'd6
`define ALU_OPX_XOR 4'd7
`define ALU_OPX_NOT 4'd8
`define ALU_OPX_NEG 4'd9
`define ALU_OPX_SHL 4'd10
`define ALU_OPX_SHR 4'd11
`define ALU_OPX_ROL 4'd12
`define ALU_OPX_ROR 4'd13
`define ALU_OPX_INC 4'd14
`define ALU_OPX_DEC 4'd15

// operand source selects.
`define ALUA_SRCX_REG_A 3'd0
`define ALUA_SRCX_ZERO  3'd1
`define ALUB_SRCX_REG_B 3'd0
`define ALUB_SRCX_U4    3'd1
`define ALUB_SRCX_U8    3'd2
`define ALUB_SRCX_U8H   3'd3

// register address selects and the fixed registers they point at.
`define REGA_ADDRX_ARGA 2'd0
`define REGA_ADDRX_RA   2'd1
`define REGA_ADDRX_RB   2'd2
`define REGB_ADDRX_ARGB 3'd0
`define REGB_ADDRX_RB   3'd1
`define REG_RA 4'd1
`define REG_RB 4'd2

`endif
